//--- common/lsu_defs.svh
// load/store unit parameters
// address, bus and index widths, plus the response wait limit

`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// virtual address width, three 16-bit AGU segments
`define LSU_ADDR_W 48

// AXI4-Lite data bus width
`define LSU_DATA_W 32

// index bits taken before extension
`define LSU_IDX_W 33

// cycles to wait for B or R before giving up
`define LSU_TIMEOUT 64

`endif

//--- common/axiLitePkg.sv
// AXI4-Lite channel payloads
// valid and ready travel as separate ports next to these

`include "lsu_defs.svh"

package axiLitePkg;

	typedef logic [`LSU_ADDR_W-1:0]   axiAddr_t;
	typedef logic [`LSU_DATA_W-1:0]   axiData_t;
	typedef logic [`LSU_DATA_W/8-1:0] axiStrb_t;

	typedef enum logic [1:0]
	{
		OKAY   = 2'b00,
		EXOKAY = 2'b01,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} axiResp_e;

	typedef struct packed
	{
		axiAddr_t addr;
		logic [2:0] prot;
	} axiAw_t;

	typedef struct packed
	{
		axiData_t data;
		axiStrb_t strb;
	} axiW_t;

	typedef struct packed
	{
		axiResp_e resp;
	} axiB_t;

	typedef struct packed
	{
		axiAddr_t addr;
		logic [2:0] prot;
	} axiAr_t;

	typedef struct packed
	{
		axiData_t data;
		axiResp_e resp;
	} axiR_t;

endpackage

//--- common/lsuPkg.sv
// load/store unit types
// address and data vectors, FSM state, command and response structs

`include "lsu_defs.svh"

package lsuPkg;

	typedef logic [`LSU_ADDR_W-1:0] addr_t;
	typedef logic [`LSU_DATA_W-1:0] data_t;

	// index shift, x1 x2 x4 x8
	typedef logic [1:0] scale_t;

	// same order as the old B/W/L/Q type field, no quad here
	typedef enum logic [1:0]
	{
		BYTE = 2'd0,
		WORD = 2'd1,
		LONG = 2'd2
	} size_e;

	typedef enum logic [1:0]
	{
		OK         = 2'd0,
		MISALIGNED = 2'd1,
		BUS_ERROR  = 2'd2,
		TIMEOUT    = 2'd3
	} status_e;

	typedef enum logic [1:0]
	{
		IDLE      = 2'd0,
		ISSUE     = 2'd1,
		WAIT_RESP = 2'd2,
		DONE      = 2'd3
	} lsuState_e;

	typedef struct packed
	{
		addr_t  base;
		addr_t  index;
		scale_t scale;
		logic   zeroExt;
		logic   wide;
		size_e  size;
		logic   write;
		data_t  wdata;
	} lsuCmd_t;

	typedef struct packed
	{
		status_e status;
		data_t   rdata;
	} lsuRsp_t;

endpackage

//--- hw/exAgu.sv
// scaled-index address generator
// base + (extended index << scale), added in three carry-select segments

`timescale 1ns/1ps

`include "lsu_defs.svh"

module exAgu
(
	input  lsuPkg::addr_t  base,
	input  lsuPkg::addr_t  index,
	input  lsuPkg::scale_t scale,
	input  logic           zeroExt,
	input  logic           wide,
	output lsuPkg::addr_t  addr
);

	localparam int SEG_W = `LSU_ADDR_W / 3;
	localparam logic [SEG_W:0] ONE = 1;

	logic           extBit;
	lsuPkg::addr_t  extIdx;
	lsuPkg::addr_t  scIdx;
	logic [SEG_W:0] sumLo;
	logic [SEG_W:0] sumMid0;
	logic [SEG_W:0] sumMid1;
	logic [SEG_W:0] sumHi0;
	logic [SEG_W:0] sumHi1;
	logic           carryMid;
	logic           carryHi;
	logic [SEG_W-1:0] segMid;
	logic [SEG_W-1:0] segHi;

	always_comb
	begin
		// only the low 33 index bits count
		extBit = zeroExt ? 1'b0 : index[`LSU_IDX_W-1];
		extIdx = {{(`LSU_ADDR_W-`LSU_IDX_W){extBit}}, index[`LSU_IDX_W-1:0]};

		case (scale)
			2'd0: scIdx = extIdx;
			2'd1: scIdx = {extIdx[`LSU_ADDR_W-2:0], 1'b0};
			2'd2: scIdx = {extIdx[`LSU_ADDR_W-3:0], 2'b0};
			default: scIdx = {extIdx[`LSU_ADDR_W-4:0], 3'b0};
		endcase

		// low segment, plain add
		sumLo = {1'b0, base[SEG_W-1:0]} + {1'b0, scIdx[SEG_W-1:0]};

		// upper segments computed for both carry-ins up front
		sumMid0 = {1'b0, base[2*SEG_W-1:SEG_W]} + {1'b0, scIdx[2*SEG_W-1:SEG_W]};
		sumMid1 = sumMid0 + ONE;
		sumHi0  = {1'b0, base[3*SEG_W-1:2*SEG_W]} + {1'b0, scIdx[3*SEG_W-1:2*SEG_W]};
		sumHi1  = sumHi0 + ONE;

		// select chain, carry ripples through the muxes only
		carryMid = sumLo[SEG_W];
		segMid   = carryMid ? sumMid1[SEG_W-1:0] : sumMid0[SEG_W-1:0];
		carryHi  = carryMid ? sumMid1[SEG_W] : sumMid0[SEG_W];

		// narrow mode keeps the top 16 bits clear
		segHi = '0;
		if (wide)
		begin
			segHi = carryHi ? sumHi1[SEG_W-1:0] : sumHi0[SEG_W-1:0];
		end

		addr = {segHi, segMid, sumLo[SEG_W-1:0]};
	end

endmodule

//--- hw/lsu/lsuTimer.sv
// response wait timer
// counts while run is high, flags expiry at the timeout count

`timescale 1ns/1ps

`include "lsu_defs.svh"

module lsuTimer
(
	input  logic clock,
	input  logic rst,
	input  logic run,
	output logic expired
);

	localparam int CNT_W = $clog2(`LSU_TIMEOUT + 1);

	logic [CNT_W-1:0] count;

	// clears on expiry too, so the flag never outlives the wait
	always_ff @(posedge clock)
	begin
		if (rst || !run || expired)
		begin
			count <= '0;
		end
		else
		begin
			count <= count + 1'b1;
		end
	end

	assign expired = (count == CNT_W'(`LSU_TIMEOUT));

	// controller must still be waiting when the limit hits
	aExpRun: assert property (@(posedge clock) disable iff (rst)
		expired |-> run);

endmodule

//--- hw/lsu/lsuCtrl.sv
// load/store sequencer
// accept, alignment check, bus phases, timeout and response hold

`timescale 1ns/1ps

module lsuCtrl
(
	input  logic              clock,
	input  logic              rst,
	input  logic              cmdValid,
	input  logic              rspReady,
	input  logic              misaligned,
	input  logic              write,
	input  logic              addrDone,
	input  logic              respDone,
	input  logic              expired,
	output logic              cmdReady,
	output logic              rspValid,
	output logic              load,
	output logic              issue,
	output logic              waitResp,
	output logic              timerRun,
	output lsuPkg::lsuState_e state,
	output logic              timedOut
);

	lsuPkg::lsuState_e nextState;

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			state <= lsuPkg::IDLE;
		end
		else
		begin
			state <= nextState;
		end
	end

	always_comb
	begin
		nextState = state;
		case (state)
			lsuPkg::IDLE:
			begin
				if (cmdValid)
				begin
					nextState = lsuPkg::ISSUE;
				end
			end
			lsuPkg::ISSUE:
			begin
				// misaligned skips the bus, answer straight away
				if (misaligned)
				begin
					nextState = lsuPkg::DONE;
				end
				else if (addrDone)
				begin
					nextState = lsuPkg::WAIT_RESP;
				end
			end
			lsuPkg::WAIT_RESP:
			begin
				if (respDone || expired)
				begin
					nextState = lsuPkg::DONE;
				end
			end
			default:
			begin
				// hold the response until taken
				if (rspReady)
				begin
					nextState = lsuPkg::IDLE;
				end
			end
		endcase
	end

	// remember why WAIT_RESP ended, a real response wins a tie
	always_ff @(posedge clock)
	begin
		if (rst || load)
		begin
			timedOut <= 1'b0;
		end
		else if (waitResp && expired && !respDone)
		begin
			timedOut <= 1'b1;
		end
	end

	assign cmdReady = (state == lsuPkg::IDLE);
	assign load     = cmdReady && cmdValid;
	assign issue    = (state == lsuPkg::ISSUE) && !misaligned;
	assign waitResp = (state == lsuPkg::WAIT_RESP);
	assign timerRun = waitResp;
	assign rspValid = (state == lsuPkg::DONE);

	// response must not be withdrawn
	aRspHold: assert property (@(posedge clock) disable iff (rst)
		rspValid && !rspReady |=> rspValid);

	// no accept while anything is in flight or pending
	aReadyIdle: assert property (@(posedge clock) disable iff (rst)
		cmdReady |-> (state == lsuPkg::IDLE) && !rspValid && !timerRun);

	// an accepted command carries a known direction
	aDirKnown: assert property (@(posedge clock) disable iff (rst)
		load |-> !$isunknown(write));

endmodule

//--- hw/lsu/lsuBusPort.sv
// AXI4-Lite master datapath
// holds the access, drives the channels, lanes and strobes, builds the response

`timescale 1ns/1ps

`include "lsu_defs.svh"

module lsuBusPort
(
	input  logic               clock,
	input  logic               rst,
	input  logic               load,
	input  logic               issue,
	input  logic               waitResp,
	input  logic               timedOut,
	input  lsuPkg::lsuCmd_t    cmd,
	input  lsuPkg::addr_t      addr,
	output axiLitePkg::axiAw_t aw,
	output logic               awValid,
	input  logic               awReady,
	output axiLitePkg::axiW_t  w,
	output logic               wValid,
	input  logic               wReady,
	input  axiLitePkg::axiB_t  b,
	input  logic               bValid,
	output logic               bReady,
	output axiLitePkg::axiAr_t ar,
	output logic               arValid,
	input  logic               arReady,
	input  axiLitePkg::axiR_t  r,
	input  logic               rValid,
	output logic               rReady,
	output logic               misaligned,
	output logic               addrDone,
	output logic               respDone,
	output lsuPkg::lsuRsp_t    rsp
);

	localparam int LANE_W = $clog2(`LSU_DATA_W / 8);

	lsuPkg::addr_t        addrQ;
	lsuPkg::size_e        sizeQ;
	logic                 writeQ;
	lsuPkg::data_t        wdataQ;
	lsuPkg::data_t        rdataQ;
	logic                 respErrQ;
	logic                 awDone;
	logic                 wDone;
	logic                 arDone;
	logic [LANE_W-1:0]    lane;
	axiLitePkg::axiStrb_t strb;
	lsuPkg::data_t        laneData;
	lsuPkg::data_t        loadData;

	function automatic logic isErr(axiLitePkg::axiResp_e resp);
		return (resp == axiLitePkg::SLVERR) || (resp == axiLitePkg::DECERR);
	endfunction

	// access payload, captured at accept
	always_ff @(posedge clock)
	begin
		if (load)
		begin
			addrQ  <= addr;
			sizeQ  <= cmd.size;
			writeQ <= cmd.write;
			wdataQ <= cmd.wdata;
		end
	end

	// per-channel completion, AW and W may finish in either order
	always_ff @(posedge clock)
	begin
		if (rst || load)
		begin
			awDone <= 1'b0;
			wDone  <= 1'b0;
			arDone <= 1'b0;
		end
		else
		begin
			awDone <= awDone || (awValid && awReady);
			wDone  <= wDone || (wValid && wReady);
			arDone <= arDone || (arValid && arReady);
		end
	end

	// response capture, store leaves rdata at zero
	always_ff @(posedge clock)
	begin
		if (load)
		begin
			rdataQ   <= '0;
			respErrQ <= 1'b0;
		end
		else if (bValid && bReady)
		begin
			respErrQ <= isErr(b.resp);
		end
		else if (rValid && rReady)
		begin
			rdataQ   <= loadData;
			respErrQ <= isErr(r.resp);
		end
	end

	assign lane = addrQ[LANE_W-1:0];

	always_comb
	begin
		// natural alignment per size
		case (sizeQ)
			lsuPkg::WORD: misaligned = addrQ[0];
			lsuPkg::LONG: misaligned = |addrQ[LANE_W-1:0];
			default: misaligned = 1'b0;
		endcase

		// strobe picks the lanes, stray upper bits stay masked
		case (sizeQ)
			lsuPkg::BYTE: strb = axiLitePkg::axiStrb_t'(1) << lane;
			lsuPkg::WORD: strb = axiLitePkg::axiStrb_t'(3) << lane;
			default: strb = '1;
		endcase
		laneData = wdataQ << {lane, 3'b000};

		// load lane down to bit 0, zero extended
		loadData = r.data >> {lane, 3'b000};
		case (sizeQ)
			lsuPkg::BYTE: loadData = {{(`LSU_DATA_W-8){1'b0}}, loadData[7:0]};
			lsuPkg::WORD: loadData = {{(`LSU_DATA_W-16){1'b0}}, loadData[15:0]};
			default: loadData = loadData;
		endcase

		// cause priority, local faults before bus faults
		if (misaligned)
			rsp.status = lsuPkg::MISALIGNED;
		else if (timedOut)
			rsp.status = lsuPkg::TIMEOUT;
		else if (respErrQ)
			rsp.status = lsuPkg::BUS_ERROR;
		else
			rsp.status = lsuPkg::OK;
		rsp.rdata = rdataQ;
	end

	// plain data access, unprivileged, secure
	assign aw = '{addr: addrQ, prot: 3'b000};
	assign ar = '{addr: addrQ, prot: 3'b000};
	assign w  = '{data: laneData, strb: strb};

	assign awValid  = issue && writeQ && !awDone;
	assign wValid   = issue && writeQ && !wDone;
	assign arValid  = issue && !writeQ && !arDone;
	assign bReady   = waitResp && writeQ;
	assign rReady   = waitResp && !writeQ;
	assign addrDone = writeQ ? (awDone && wDone) : arDone;
	assign respDone = (bValid && bReady) || (rValid && rReady);

	// valids must stay up until the slave takes them
	aAwHold: assert property (@(posedge clock) disable iff (rst)
		awValid && !awReady |=> awValid);
	aWHold: assert property (@(posedge clock) disable iff (rst)
		wValid && !wReady |=> wValid);
	aArHold: assert property (@(posedge clock) disable iff (rst)
		arValid && !arReady |=> arValid);

endmodule

//--- hw/lsuTop.sv
// load/store unit top
// AGU, sequencer, timeout timer and AXI4-Lite bus port

`timescale 1ns/1ps

module lsuTop
(
	input  logic               clock,
	input  logic               rst,
	input  logic               cmdValid,
	output logic               cmdReady,
	input  lsuPkg::lsuCmd_t    cmd,
	output logic               rspValid,
	input  logic               rspReady,
	output lsuPkg::lsuRsp_t    rsp,
	output axiLitePkg::axiAw_t aw,
	output logic               awValid,
	input  logic               awReady,
	output axiLitePkg::axiW_t  w,
	output logic               wValid,
	input  logic               wReady,
	input  axiLitePkg::axiB_t  b,
	input  logic               bValid,
	output logic               bReady,
	output axiLitePkg::axiAr_t ar,
	output logic               arValid,
	input  logic               arReady,
	input  axiLitePkg::axiR_t  r,
	input  logic               rValid,
	output logic               rReady
);

	lsuPkg::addr_t effAddr;
	logic          load;
	logic          issue;
	logic          waitResp;
	logic          timerRun;
	logic          timedOut;
	logic          expired;
	logic          misaligned;
	logic          addrDone;
	logic          respDone;

	// address from the live command, captured by the bus port on accept
	exAgu i_agu
	(
		.base    (cmd.base),
		.index   (cmd.index),
		.scale   (cmd.scale),
		.zeroExt (cmd.zeroExt),
		.wide    (cmd.wide),
		.addr    (effAddr)
	);

	// state not needed at this level
	lsuCtrl i_ctrl
	(
		.clock      (clock),
		.rst        (rst),
		.cmdValid   (cmdValid),
		.rspReady   (rspReady),
		.misaligned (misaligned),
		.write      (cmd.write),
		.addrDone   (addrDone),
		.respDone   (respDone),
		.expired    (expired),
		.cmdReady   (cmdReady),
		.rspValid   (rspValid),
		.load       (load),
		.issue      (issue),
		.waitResp   (waitResp),
		.timerRun   (timerRun),
		.state      (),
		.timedOut   (timedOut)
	);

	lsuTimer i_timer
	(
		.clock   (clock),
		.rst     (rst),
		.run     (timerRun),
		.expired (expired)
	);

	lsuBusPort i_busPort
	(
		.clock      (clock),
		.rst        (rst),
		.load       (load),
		.issue      (issue),
		.waitResp   (waitResp),
		.timedOut   (timedOut),
		.cmd        (cmd),
		.addr       (effAddr),
		.aw         (aw),
		.awValid    (awValid),
		.awReady    (awReady),
		.w          (w),
		.wValid     (wValid),
		.wReady     (wReady),
		.b          (b),
		.bValid     (bValid),
		.bReady     (bReady),
		.ar         (ar),
		.arValid    (arValid),
		.arReady    (arReady),
		.r          (r),
		.rValid     (rValid),
		.rReady     (rReady),
		.misaligned (misaligned),
		.addrDone   (addrDone),
		.respDone   (respDone),
		.rsp        (rsp)
	);

endmodule

//--- bench/tbLsuTop.sv
// load/store unit testbench
// LCG stimulus, AXI4-Lite memory model with random readies, reference model
// and concurrent assertions on addresses, strobes, latency and responses

`timescale 1ns/1ps

`include "lsu_defs.svh"

module tbLsuTop;

	localparam int WAIT_LIMIT = 4 * `LSU_TIMEOUT;

	logic               clock = 1'b0;
	logic               rst;
	logic               cmdValid;
	logic               cmdReady;
	lsuPkg::lsuCmd_t    cmd;
	logic               rspValid;
	logic               rspReady;
	lsuPkg::lsuRsp_t    rsp;
	axiLitePkg::axiAw_t aw;
	logic               awValid;
	logic               awReady = 1'b0;
	axiLitePkg::axiW_t  w;
	logic               wValid;
	logic               wReady = 1'b0;
	axiLitePkg::axiB_t  b = '0;
	logic               bValid = 1'b0;
	logic               bReady;
	axiLitePkg::axiAr_t ar;
	logic               arValid;
	logic               arReady = 1'b0;
	axiLitePkg::axiR_t  r = '0;
	logic               rValid = 1'b0;
	logic               rReady;

	// memory model state
	logic [31:0]        mem [256];
	logic [31:0]        memState = 32'd4;
	logic               awGot = 1'b0;
	logic               wGot = 1'b0;
	lsuPkg::addr_t      awAddr = '0;
	axiLitePkg::axiW_t  wBeat = '0;
	logic               errNext;
	logic               withholdNext;

	// reference model and expectations for the access in flight
	logic [31:0]        refMem [256];
	logic [31:0]        stimState = 32'd4;
	lsuPkg::addr_t      expAddr;
	logic               expMis;
	logic               expWrite;
	logic [3:0]         expStrb;
	logic [31:0]        expWmask;
	logic [31:0]        expWdata;
	lsuPkg::status_e    expStatus;
	logic [31:0]        expRdata;
	logic               busy = 1'b0;
	int                 sinceAccept = 0;
	int                 sinceAddr = 0;

	int errors = 0;
	int timeouts = 0;
	int accesses = 0;

	lsuTop i_lsuTop
	(
		.clock    (clock),
		.rst      (rst),
		.cmdValid (cmdValid),
		.cmdReady (cmdReady),
		.cmd      (cmd),
		.rspValid (rspValid),
		.rspReady (rspReady),
		.rsp      (rsp),
		.aw       (aw),
		.awValid  (awValid),
		.awReady  (awReady),
		.w        (w),
		.wValid   (wValid),
		.wReady   (wReady),
		.b        (b),
		.bValid   (bValid),
		.bReady   (bReady),
		.ar       (ar),
		.arValid  (arValid),
		.arReady  (arReady),
		.r        (r),
		.rValid   (rValid),
		.rReady   (rReady)
	);

	always #50 clock = ~clock;

	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// two LCG steps, upper halves only
	function automatic logic [31:0] randWord();
		logic [15:0] hi;
		stimState = lcgNext(stimState);
		hi = stimState[31:16];
		stimState = lcgNext(stimState);
		return {hi, stimState[31:16]};
	endfunction

	// initial memory contents, every index bit matters
	function automatic logic [31:0] fillWord(input logic [7:0] i);
		return ({24'h0, i} + 32'd1) * 32'h9E3779B1 ^ {i, ~i, i, ~i};
	endfunction

	// base + (extended low 33 index bits << scale), top 16 bits cleared if narrow
	function automatic lsuPkg::addr_t expectAddr(input lsuPkg::lsuCmd_t c);
		logic [63:0] idx;
		logic [63:0] sum;
		if (c.zeroExt)
			idx = {{(64-`LSU_IDX_W){1'b0}}, c.index[`LSU_IDX_W-1:0]};
		else
			idx = {{(64-`LSU_IDX_W){c.index[`LSU_IDX_W-1]}}, c.index[`LSU_IDX_W-1:0]};
		sum = {16'h0, c.base} + (idx << c.scale);
		if (!c.wide)
			sum[47:32] = 16'h0;
		return sum[47:0];
	endfunction

	function automatic logic isMisaligned(input lsuPkg::size_e size, input lsuPkg::addr_t a);
		case (size)
			lsuPkg::WORD: return a[0];
			lsuPkg::LONG: return a[1:0] != 2'b00;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic [3:0] laneStrobe(input lsuPkg::size_e size, input lsuPkg::addr_t a);
		case (size)
			lsuPkg::BYTE: return 4'b0001 << a[1:0];
			lsuPkg::WORD: return 4'b0011 << a[1:0];
			default: return 4'b1111;
		endcase
	endfunction

	// one byte of ones per strobe bit
	function automatic logic [31:0] strobeMask(input logic [3:0] s);
		return {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
	endfunction

	function automatic lsuPkg::lsuCmd_t randomCmd();
		lsuPkg::lsuCmd_t c;
		logic [31:0] sel;
		c.base = lsuPkg::addr_t'({randWord(), randWord()});
		c.index = lsuPkg::addr_t'({randWord(), randWord()});
		sel = randWord();
		c.scale = sel[1:0];
		c.zeroExt = sel[2];
		c.wide = sel[3];
		c.write = sel[4];
		c.size = lsuPkg::size_e'(2'(sel[15:8] % 8'd3));
		c.wdata = randWord();
		return c;
	endfunction

	// AXI4-Lite slave, 256 words at addr mod 1024, readies toggle at random
	always @(posedge clock)
	begin
		if (rst)
		begin
			awReady <= 1'b0;
			wReady <= 1'b0;
			arReady <= 1'b0;
			bValid <= 1'b0;
			rValid <= 1'b0;
			awGot <= 1'b0;
			wGot <= 1'b0;
		end
		else
		begin
			memState = lcgNext(memState);
			awReady <= memState[20];
			wReady <= memState[23];
			arReady <= memState[26];
			if (awValid && awReady)
			begin
				awAddr <= aw.addr;
				awGot <= 1'b1;
			end
			if (wValid && wReady)
			begin
				wBeat <= w;
				wGot <= 1'b1;
			end
			// write lands once both beats are in
			if (awGot && wGot)
			begin
				awGot <= 1'b0;
				wGot <= 1'b0;
				if (!withholdNext)
				begin
					if (!errNext)
					begin
						for (int k = 0; k < 4; k++)
						begin
							if (wBeat.strb[k])
								mem[awAddr[9:2]][8*k +: 8] = wBeat.data[8*k +: 8];
						end
					end
					b <= '{resp: errNext ? axiLitePkg::SLVERR : axiLitePkg::OKAY};
					bValid <= 1'b1;
				end
			end
			if (bValid && bReady)
				bValid <= 1'b0;
			if (arValid && arReady && !withholdNext)
			begin
				r <= '{data: mem[ar.addr[9:2]],
					resp: errNext ? axiLitePkg::SLVERR : axiLitePkg::OKAY};
				rValid <= 1'b1;
			end
			if (rValid && rReady)
				rValid <= 1'b0;
		end
	end

	// cycle counts since accept and since the last address or data beat
	always @(posedge clock)
	begin
		if (rst)
		begin
			busy <= 1'b0;
			sinceAccept <= 0;
			sinceAddr <= 0;
		end
		else
		begin
			if (cmdValid && cmdReady)
			begin
				busy <= 1'b1;
				sinceAccept <= 1;
			end
			else
				sinceAccept <= sinceAccept + 1;
			if (rspValid && rspReady)
				busy <= 1'b0;
			if ((awValid && awReady) || (wValid && wReady) || (arValid && arReady))
				sinceAddr <= 1;
			else
				sinceAddr <= sinceAddr + 1;
		end
	end

	aResetState: assert property (@(posedge clock) $fell(rst) |->
		cmdReady && !rspValid && !awValid && !wValid && !arValid && !bReady && !rReady)
		else begin errors++; $display("Error %0t: bad outputs right after reset", $time); end

	// plain data access carries prot zero
	aArAddr: assert property (@(posedge clock) disable iff (rst)
		arValid |-> ar.addr == expAddr && ar.prot == 3'b000)
		else begin errors++; $display("Error %0t: AR address %h prot %0d, expected %h",
			$time, $sampled(ar.addr), $sampled(ar.prot), $sampled(expAddr)); end

	aAwAddr: assert property (@(posedge clock) disable iff (rst)
		awValid |-> aw.addr == expAddr && aw.prot == 3'b000)
		else begin errors++; $display("Error %0t: AW address %h prot %0d, expected %h",
			$time, $sampled(aw.addr), $sampled(aw.prot), $sampled(expAddr)); end

	aStrobe: assert property (@(posedge clock) disable iff (rst)
		wValid |-> w.strb == expStrb && (w.data & expWmask) == (expWdata & expWmask))
		else begin errors++; $display("Error %0t: W beat %h/%h, expected %h/%h", $time,
			$sampled(w.data), $sampled(w.strb), $sampled(expWdata), $sampled(expStrb)); end

	// aligned access puts its valids up one cycle after accept
	aIssue: assert property (@(posedge clock) disable iff (rst)
		busy && sinceAccept == 1 && !expMis |-> (expWrite ? awValid && wValid : arValid))
		else begin errors++; $display("Error %0t: bus valid late after accept", $time); end

	aNoBus: assert property (@(posedge clock) disable iff (rst)
		busy && expMis |-> !awValid && !wValid && !arValid)
		else begin errors++; $display("Error %0t: bus valid on misaligned access", $time); end

	aMisLatency: assert property (@(posedge clock) disable iff (rst)
		$rose(rspValid) && expMis |-> sinceAccept == 2)
		else begin errors++; $display("Error %0t: misaligned response after %0d cycles",
			$time, $sampled(sinceAccept)); end

	aTimeoutLatency: assert property (@(posedge clock) disable iff (rst)
		$rose(rspValid) && expStatus == lsuPkg::TIMEOUT |-> sinceAddr >= `LSU_TIMEOUT)
		else begin errors++; $display("Error %0t: timeout after only %0d cycles",
			$time, $sampled(sinceAddr)); end

	aStatus: assert property (@(posedge clock) disable iff (rst)
		rspValid && rspReady |-> rsp.status == expStatus)
		else begin errors++; $display("Error %0t: status %0d, expected %0d",
			$time, $sampled(rsp.status), $sampled(expStatus)); end

	aRdata: assert property (@(posedge clock) disable iff (rst)
		rspValid && rspReady && !expWrite && expStatus == lsuPkg::OK |-> rsp.rdata == expRdata)
		else begin errors++; $display("Error %0t: load data %h, expected %h",
			$time, $sampled(rsp.rdata), $sampled(expRdata)); end

	// back-pressure keeps the response frozen and blocks new commands
	aRspHold: assert property (@(posedge clock) disable iff (rst)
		rspValid && !rspReady |=> rspValid && $stable(rsp) && !cmdReady)
		else begin errors++; $display("Error %0t: response moved under back-pressure", $time); end

	task automatic finishRun();
		$display("checks failed %0d, wait timeouts %0d, accesses %0d",
			errors, timeouts, accesses);
		if (errors == 0 && timeouts == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	endtask

	task automatic giveUp(input string what);
		timeouts++;
		$display("timeout: no %s within %0d cycles", what, WAIT_LIMIT);
		finishRun();
	endtask

	task automatic waitCmdReady();
		int n;
		n = 0;
		@(negedge clock);
		while (!cmdReady && n < WAIT_LIMIT)
		begin
			@(negedge clock);
			n++;
		end
		if (!cmdReady)
			giveUp("command ready");
	endtask

	task automatic waitRspValid();
		int n;
		n = 0;
		@(negedge clock);
		while (!rspValid && n < WAIT_LIMIT)
		begin
			@(negedge clock);
			n++;
		end
		if (!rspValid)
			giveUp("response valid");
	endtask

	// one command through accept and response, expectations set up front
	task automatic runAccess(input lsuPkg::lsuCmd_t c, input logic slvErr,
		input logic withhold, input int holdCycles);
		lsuPkg::addr_t   a;
		logic            mis;
		logic [3:0]      strb;
		logic [31:0]     lanes;
		logic [31:0]     word;
		lsuPkg::status_e st;
		a = expectAddr(c);
		mis = isMisaligned(c.size, a);
		strb = laneStrobe(c.size, a);
		lanes = c.wdata << (8 * a[1:0]);
		word = refMem[a[9:2]] >> (8 * a[1:0]);
		case (c.size)
			lsuPkg::BYTE: word = {24'h0, word[7:0]};
			lsuPkg::WORD: word = {16'h0, word[15:0]};
			default: word = word;
		endcase
		if (mis)
			st = lsuPkg::MISALIGNED;
		else if (withhold)
			st = lsuPkg::TIMEOUT;
		else if (slvErr)
			st = lsuPkg::BUS_ERROR;
		else
			st = lsuPkg::OK;
		@(posedge clock);
		cmd <= c;
		cmdValid <= 1'b1;
		expAddr <= a;
		expMis <= mis;
		expWrite <= c.write;
		expStrb <= strb;
		expWmask <= strobeMask(strb);
		expWdata <= lanes;
		expStatus <= st;
		expRdata <= word;
		errNext <= slvErr;
		withholdNext <= withhold;
		waitCmdReady();
		// this edge is the accept
		@(posedge clock);
		cmdValid <= 1'b0;
		waitRspValid();
		repeat (holdCycles) @(negedge clock);
		@(posedge clock);
		rspReady <= 1'b1;
		@(posedge clock);
		rspReady <= 1'b0;
		errNext <= 1'b0;
		withholdNext <= 1'b0;
		if (st == lsuPkg::OK && c.write)
		begin
			for (int k = 0; k < 4; k++)
			begin
				if (strb[k])
					refMem[a[9:2]][8*k +: 8] = lanes[8*k +: 8];
			end
		end
		accesses++;
	endtask

	initial
	begin
		lsuPkg::lsuCmd_t c;
		logic [31:0] sel;
		for (int i = 0; i < 256; i++)
		begin
			mem[i] = fillWord(8'(i));
			refMem[i] = fillWord(8'(i));
		end
		rst = 1'b1;
		cmdValid = 1'b0;
		cmd = '0;
		rspReady = 1'b0;
		errNext = 1'b0;
		withholdNext = 1'b0;
		expAddr = '0;
		expMis = 1'b0;
		expWrite = 1'b0;
		expStrb = '0;
		expWmask = '0;
		expWdata = '0;
		expStatus = lsuPkg::OK;
		expRdata = '0;
		repeat (8) @(posedge clock);
		rst <= 1'b0;
		waitCmdReady();

		// AGU sweep, byte loads so every address reaches AR
		for (int s = 0; s < 4; s++)
		begin
			for (int k = 0; k < 8; k++)
			begin
				c = randomCmd();
				c.scale = lsuPkg::scale_t'(s);
				c.zeroExt = k[0];
				c.wide = k[1];
				// index sign bit, negative when sign extended
				c.index[`LSU_IDX_W-1] = k[2];
				c.size = lsuPkg::BYTE;
				c.write = 1'b0;
				runAccess(c, 1'b0, 1'b0, 0);
			end
		end

		// long store then load at the same aligned address
		for (int k = 0; k < 8; k++)
		begin
			c = randomCmd();
			c.size = lsuPkg::LONG;
			c.base[1:0] = 2'b00;
			c.index[1:0] = 2'b00;
			c.write = 1'b1;
			runAccess(c, 1'b0, 1'b0, k % 3);
			c.write = 1'b0;
			runAccess(c, 1'b0, 1'b0, 0);
		end

		// byte and word stores, narrow load back, then the whole word
		for (int k = 0; k < 12; k++)
		begin
			c = randomCmd();
			c.index[1:0] = 2'b00;
			c.size = k[0] ? lsuPkg::WORD : lsuPkg::BYTE;
			if (k[0])
				c.base[0] = 1'b0;
			c.write = 1'b1;
			runAccess(c, 1'b0, 1'b0, 0);
			c.write = 1'b0;
			runAccess(c, 1'b0, 1'b0, 0);
			c.size = lsuPkg::LONG;
			c.base[1:0] = 2'b00;
			runAccess(c, 1'b0, 1'b0, 0);
		end

		// misaligned words and longs, both directions
		for (int k = 0; k < 6; k++)
		begin
			c = randomCmd();
			c.index[1:0] = 2'b00;
			c.size = k[0] ? lsuPkg::WORD : lsuPkg::LONG;
			c.base[1:0] = k[0] ? {k[2], 1'b1} : 2'(k / 2 + 1);
			c.write = k[1];
			runAccess(c, 1'b0, 1'b0, 1);
		end

		// slave error on store and load, then confirm the store did not land
		c = randomCmd();
		c.size = lsuPkg::LONG;
		c.base[1:0] = 2'b00;
		c.index[1:0] = 2'b00;
		c.write = 1'b1;
		runAccess(c, 1'b1, 1'b0, 0);
		c.write = 1'b0;
		runAccess(c, 1'b1, 1'b0, 0);
		runAccess(c, 1'b0, 1'b0, 0);

		// withheld responses, held under back-pressure for a while
		runAccess(c, 1'b0, 1'b1, 4);
		c.write = 1'b1;
		runAccess(c, 1'b0, 1'b1, 4);
		c.write = 1'b0;
		runAccess(c, 1'b0, 1'b0, 0);

		// free mix, some slave errors and random hold times
		for (int k = 0; k < 24; k++)
		begin
			c = randomCmd();
			sel = randWord();
			runAccess(c, sel[3:0] == 4'h0, 1'b0, int'(sel[9:8]));
		end

		repeat (4) @(posedge clock);
		finishRun();
	end

endmodule

//--- lsuSub.f
+incdir+common
common/axiLitePkg.sv
common/lsuPkg.sv
hw/exAgu.sv
hw/lsu/lsuTimer.sv
hw/lsu/lsuCtrl.sv
hw/lsu/lsuBusPort.sv
hw/lsuTop.sv
bench/tbLsuTop.sv

//--- run.sh
#!/bin/sh
# build the load/store unit testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tbLsuTop -f lsuSub.f --Mdir build -o simLsu

# the run's own output decides pass or fail
out=$(./build/simLsu 2>&1) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "test passed"
